// ==== src/mot_pkg.sv ====
// Shared opcodes, field layout and micro-op helpers for the translation stage, imported by each block
package mot_pkg;

	// =========================================================================
	// Field widths and instruction layout
	// =========================================================================

	// Raw instruction width as delivered by fetch
	localparam int INSTR_W = 32;
	// Opcode width, shared by instructions and micro-ops
	localparam int OP_W = 4;
	// Architectural register number width (64 registers)
	localparam int REG_W = 6;
	// A micro-op is opcode, dst, src1 and src2 from the top down
	localparam int UOP_W = OP_W + 3 * REG_W;

	// Low bit of each register field inside a raw instruction
	localparam int RD_LSB  = 4;
	localparam int RS1_LSB = 10;
	localparam int RS2_LSB = 16;

	// Register 63 serves as the stack pointer for PUSH and POP
	localparam logic [REG_W-1:0] SP_REG = 6'd63;

	// Two hardware threads share the stage
	localparam int THREAD_W    = 1;
	localparam int NUM_THREADS = 2 ** THREAD_W;

	// Longest expansion of any instruction (MOVM with four moves)
	localparam int MAX_SEQ = 4;

	// =========================================================================
	// Opcode and mode encodings
	// =========================================================================

	// Instruction opcodes; any code not listed decodes as illegal
	typedef enum logic [OP_W-1:0] {
		OP_NOP   = 4'd0,
		OP_ADD   = 4'd1,
		OP_SUB   = 4'd2,
		OP_LOAD  = 4'd3,
		OP_STORE = 4'd4,
		OP_PUSH  = 4'd5,
		OP_POP   = 4'd6,
		OP_MOVM  = 4'd7,
		OP_SYS   = 4'd8
	} instr_op_e;

	// Micro-op opcodes issued to the back end
	typedef enum logic [OP_W-1:0] {
		U_NOP  = 4'd0,
		U_ADD  = 4'd1,
		U_SUB  = 4'd2,
		U_LD   = 4'd3,
		U_ST   = 4'd4,
		U_INC  = 4'd5,
		U_DEC  = 4'd6,
		U_MOV  = 4'd7,
		U_SYS  = 4'd8,
		U_TRAP = 4'd9
	} uop_op_e;

	// Per-thread operating mode; user mode traps on SYS
	typedef enum logic {
		OM_USER  = 1'b0,
		OM_SUPER = 1'b1
	} om_e;

	// =========================================================================
	// Helpers
	// =========================================================================

	// Width of a counter that must reach max_uops inclusive
	function automatic int cnt_w(int max_uops);
		return $clog2(max_uops + 1);
	endfunction

	// Assemble one micro-op word from its opcode and register fields
	function automatic logic [UOP_W-1:0] pack_uop(uop_op_e op, logic [REG_W-1:0] dst,
			logic [REG_W-1:0] src1, logic [REG_W-1:0] src2);
		return {op, dst, src1, src2};
	endfunction

endpackage

// ==== src/mot_cfg_regs.sv ====
// Per-thread operating-mode registers, written by the host over a four-phase req/ack port
`timescale 1ns/100ps

module mot_cfg_regs (
	input  logic                                    clk,
	input  logic                                    arst_n,
	input  logic                                    cfg_req,
	input  logic [mot_pkg::THREAD_W-1:0]            cfg_thread,
	input  mot_pkg::om_e                            cfg_om,
	output logic                                    cfg_ack,
	output mot_pkg::om_e [mot_pkg::NUM_THREADS-1:0] thread_om
);

	import mot_pkg::*;

	// =========================================================================
	// Four-phase handshake
	// =========================================================================

	// A write happens only while req is high and ack has not yet answered it
	// The ack flop then stays high for as long as req is held, which blocks
	// a second write from the same request
	logic wr_en;

	assign wr_en = cfg_req & ~cfg_ack;

	// Ack simply follows req one edge later
	// Rising req gives rising ack on the next edge (phase 2)
	// Falling req gives falling ack on the edge after it is seen low (phase 4)
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg_ack <= 1'b0;
		end else begin
			cfg_ack <= cfg_req;
		end
	end

	// =========================================================================
	// Mode registers
	// =========================================================================

	// Both threads come out of reset in user mode
	// The new mode appears on the same edge that raises ack, so a group
	// captured on that edge still sees the old value at its decoder input
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int t = 0; t < NUM_THREADS; t++) begin
				thread_om[t] <= OM_USER;
			end
		end else if (wr_en) begin
			// Only the addressed thread changes
			thread_om[cfg_thread] <= cfg_om;
		end
	end

endmodule

// ==== src/microop_mem.sv ====
// One lane of micro-op translation; decodes a raw instruction and registers its micro-op list
`timescale 1ns/100ps

module microop_mem #(
	parameter  int MAX_UOPS = 4,
	localparam int CNT_W    = mot_pkg::cnt_w(MAX_UOPS)
) (
	input  logic                                     clk,
	input  logic                                     arst_n,
	input  logic                                     en,
	input  mot_pkg::om_e                             om,
	input  logic [mot_pkg::INSTR_W-1:0]              ir,
	output logic [CNT_W-1:0]                         count,
	output logic [MAX_UOPS-1:0][mot_pkg::UOP_W-1:0] uop
);

	import mot_pkg::*;

	// The expansion buffer must hold the longest sequence and also cover
	// every output slot, so it takes the larger of the two sizes
	localparam int SEQ_N     = (MAX_UOPS > MAX_SEQ) ? MAX_UOPS : MAX_SEQ;
	localparam int SEQ_CNT_W = cnt_w(MAX_SEQ);

	// =========================================================================
	// Field extraction
	// =========================================================================

	instr_op_e                   op;
	logic [REG_W-1:0]            rd;
	logic [REG_W-1:0]            rs1;
	logic [REG_W-1:0]            rs2;
	logic [SEQ_N-1:0][UOP_W-1:0] seq;
	logic [SEQ_CNT_W-1:0]        seq_n;
	logic [CNT_W-1:0]            nxt_count;

	// Codes above OP_SYS land in the default arm below and trap
	assign op  = instr_op_e'(ir[OP_W-1:0]);
	assign rd  = ir[RD_LSB +: REG_W];
	assign rs1 = ir[RS1_LSB +: REG_W];
	assign rs2 = ir[RS2_LSB +: REG_W];

	// =========================================================================
	// Expansion
	// =========================================================================

	// Unused slots stay all zero, which reads back as U_NOP with zero fields
	always_comb begin
		seq   = '0;
		seq_n = '0;
		case (op)
			OP_NOP: begin
				// Nothing is issued for a NOP
				seq_n = '0;
			end
			OP_ADD: begin
				seq[0] = pack_uop(U_ADD, rd, rs1, rs2);
				seq_n  = SEQ_CNT_W'(1);
			end
			OP_SUB: begin
				seq[0] = pack_uop(U_SUB, rd, rs1, rs2);
				seq_n  = SEQ_CNT_W'(1);
			end
			OP_LOAD: begin
				// Address comes from rs1, result goes to rd
				seq[0] = pack_uop(U_LD, rd, rs1, '0);
				seq_n  = SEQ_CNT_W'(1);
			end
			OP_STORE: begin
				// Store has no destination; rs1 is the address, rs2 the data
				seq[0] = pack_uop(U_ST, '0, rs1, rs2);
				seq_n  = SEQ_CNT_W'(1);
			end
			OP_PUSH: begin
				// Pre-decrement the stack pointer, then store rs1 at it
				seq[0] = pack_uop(U_DEC, SP_REG, SP_REG, '0);
				seq[1] = pack_uop(U_ST, '0, SP_REG, rs1);
				seq_n  = SEQ_CNT_W'(2);
			end
			OP_POP: begin
				// Load from the stack pointer, then post-increment it
				seq[0] = pack_uop(U_LD, rd, SP_REG, '0);
				seq[1] = pack_uop(U_INC, SP_REG, SP_REG, '0);
				seq_n  = SEQ_CNT_W'(2);
			end
			OP_MOVM: begin
				// Low two bits of rs2 give the move count minus one
				seq_n = SEQ_CNT_W'(rs2[1:0]) + SEQ_CNT_W'(1);
				for (int i = 0; i < MAX_SEQ; i++) begin
					// Register numbers wrap at 63 through the 6-bit add
					if (i < seq_n) begin
						seq[i] = pack_uop(U_MOV, rd + REG_W'(i), rs1 + REG_W'(i), '0);
					end
				end
			end
			OP_SYS: begin
				// System call is only allowed from supervisor mode
				if (om == OM_SUPER) begin
					seq[0] = pack_uop(U_SYS, '0, '0, '0);
				end else begin
					seq[0] = pack_uop(U_TRAP, '0, '0, '0);
				end
				seq_n = SEQ_CNT_W'(1);
			end
			default: begin
				// Illegal opcode
				seq[0] = pack_uop(U_TRAP, '0, '0, '0);
				seq_n  = SEQ_CNT_W'(1);
			end
		endcase
	end

	// Clip the count when a stage is built with fewer slots than the
	// longest sequence; the trailing micro-ops are then dropped
	assign nxt_count = (seq_n > MAX_UOPS) ? CNT_W'(MAX_UOPS) : CNT_W'(seq_n);

	// =========================================================================
	// Output registers
	// =========================================================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			count <= '0;
		end else if (en) begin
			count <= nxt_count;
		end
	end

	// Micro-op payload only loads while the stage is enabled
	always_ff @(posedge clk) begin
		if (en) begin
			uop <= seq[MAX_UOPS-1:0];
		end
	end

endmodule

// ==== src/pipeline_mot.sv ====
// Micro-op translation stage; registers the fetch group header and expands each lane
`timescale 1ns/100ps

module pipeline_mot #(
	parameter  int MWIDTH   = 2,
	parameter  int MAX_UOPS = 4,
	parameter  int TAG_W    = 8,
	localparam int CNT_W    = mot_pkg::cnt_w(MAX_UOPS)
) (
	input  logic                                                 clk,
	input  logic                                                 arst_n,
	input  logic                                                 en,
	input  logic                                                 stomp,
	input  logic [MWIDTH-1:0]                                    in_valid,
	input  logic [mot_pkg::THREAD_W-1:0]                         in_thread,
	input  logic [TAG_W-1:0]                                     in_tag,
	input  logic [MWIDTH-1:0][mot_pkg::INSTR_W-1:0]              in_instr,
	input  mot_pkg::om_e [mot_pkg::NUM_THREADS-1:0]              thread_om,
	output logic [MWIDTH-1:0]                                    out_valid,
	output logic [mot_pkg::THREAD_W-1:0]                         out_thread,
	output logic [TAG_W-1:0]                                     out_tag,
	output logic [MWIDTH-1:0][CNT_W-1:0]                         uop_count,
	output logic [MWIDTH-1:0][MAX_UOPS-1:0][mot_pkg::UOP_W-1:0] uop
);

	import mot_pkg::*;

	// Every lane in a group belongs to the same thread, so one mode lookup
	// feeds all decoders
	om_e grp_om;

	assign grp_om = thread_om[in_thread];

	// =========================================================================
	// Group header
	// =========================================================================

	// Lane valid bits are the only control state here
	// A stomp kills the whole group being captured
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_valid <= '0;
		end else if (en) begin
			out_valid <= stomp ? '0 : in_valid;
		end
	end

	// Thread and tag pass through even for a stomped group so later
	// stages can still match it up
	always_ff @(posedge clk) begin
		if (en) begin
			out_thread <= in_thread;
			out_tag    <= in_tag;
		end
	end

	// =========================================================================
	// Per-lane translation
	// =========================================================================

	// Decoders run on every lane regardless of valid; downstream ignores
	// the count and micro-ops of invalid lanes
	for (genvar g = 0; g < MWIDTH; g++) begin : g_lane
		microop_mem #(
			.MAX_UOPS(MAX_UOPS)
		) u_uop (
			.clk   (clk),
			.arst_n(arst_n),
			.en    (en),
			.om    (grp_om),
			.ir    (in_instr[g]),
			.count (uop_count[g]),
			.uop   (uop[g])
		);
	end

endmodule

// ==== src/mot_top.sv ====
// Top level of the translation subsystem; joins the mode register block and the stage
`timescale 1ns/100ps

module mot_top #(
	parameter  int MWIDTH   = 2,
	parameter  int MAX_UOPS = 4,
	parameter  int TAG_W    = 8,
	localparam int CNT_W    = mot_pkg::cnt_w(MAX_UOPS)
) (
	input  logic                                                 clk,
	input  logic                                                 arst_n,
	// Host configuration port
	input  logic                                                 cfg_req,
	input  logic [mot_pkg::THREAD_W-1:0]                         cfg_thread,
	input  mot_pkg::om_e                                         cfg_om,
	output logic                                                 cfg_ack,
	// Fetch group in
	input  logic                                                 en,
	input  logic                                                 stomp,
	input  logic [MWIDTH-1:0]                                    in_valid,
	input  logic [mot_pkg::THREAD_W-1:0]                         in_thread,
	input  logic [TAG_W-1:0]                                     in_tag,
	input  logic [MWIDTH-1:0][mot_pkg::INSTR_W-1:0]              in_instr,
	// Translated group out
	output logic [MWIDTH-1:0]                                    out_valid,
	output logic [mot_pkg::THREAD_W-1:0]                         out_thread,
	output logic [TAG_W-1:0]                                     out_tag,
	output logic [MWIDTH-1:0][CNT_W-1:0]                         uop_count,
	output logic [MWIDTH-1:0][MAX_UOPS-1:0][mot_pkg::UOP_W-1:0] uop
);

	import mot_pkg::*;

	// Current mode of each thread, from the register block to the stage
	om_e [NUM_THREADS-1:0] thread_om;

	mot_cfg_regs u_cfg (
		.clk       (clk),
		.arst_n    (arst_n),
		.cfg_req   (cfg_req),
		.cfg_thread(cfg_thread),
		.cfg_om    (cfg_om),
		.cfg_ack   (cfg_ack),
		.thread_om (thread_om)
	);

	pipeline_mot #(
		.MWIDTH  (MWIDTH),
		.MAX_UOPS(MAX_UOPS),
		.TAG_W   (TAG_W)
	) u_mot (
		.clk       (clk),
		.arst_n    (arst_n),
		.en        (en),
		.stomp     (stomp),
		.in_valid  (in_valid),
		.in_thread (in_thread),
		.in_tag    (in_tag),
		.in_instr  (in_instr),
		.thread_om (thread_om),
		.out_valid (out_valid),
		.out_thread(out_thread),
		.out_tag   (out_tag),
		.uop_count (uop_count),
		.uop       (uop)
	);

endmodule

// ==== tb/mot_checker.sv ====
// Watcher for the translation subsystem; models mode writes and translation and compares the DUT
`timescale 1ns/100ps

module mot_checker #(
	parameter  int MWIDTH   = 2,
	parameter  int MAX_UOPS = 4,
	parameter  int TAG_W    = 8,
	localparam int CNT_W    = $clog2(MAX_UOPS + 1)
) (
	input  logic                                                 clk,
	input  logic                                                 arst_n,
	input  logic                                                 cfg_req,
	input  logic [mot_pkg::THREAD_W-1:0]                         cfg_thread,
	input  mot_pkg::om_e                                         cfg_om,
	input  logic                                                 cfg_ack,
	input  logic                                                 en,
	input  logic                                                 stomp,
	input  logic [MWIDTH-1:0]                                    in_valid,
	input  logic [mot_pkg::THREAD_W-1:0]                         in_thread,
	input  logic [TAG_W-1:0]                                     in_tag,
	input  logic [MWIDTH-1:0][31:0]                              in_instr,
	input  logic [MWIDTH-1:0]                                    out_valid,
	input  logic [mot_pkg::THREAD_W-1:0]                         out_thread,
	input  logic [TAG_W-1:0]                                     out_tag,
	input  logic [MWIDTH-1:0][CNT_W-1:0]                         uop_count,
	input  logic [MWIDTH-1:0][MAX_UOPS-1:0][mot_pkg::UOP_W-1:0] uop,
	output int                                                   error_count,
	output int                                                   check_count
);

	import mot_pkg::*;

	// =========================================================================
	// Reference model state
	// =========================================================================

	om_e                                     mode_m [2];
	logic                                    exp_ack;
	logic                                    have_group;
	logic [MWIDTH-1:0]                       exp_valid;
	logic [THREAD_W-1:0]                     exp_thread;
	logic [TAG_W-1:0]                        exp_tag;
	int                                      exp_cnt [MWIDTH];
	logic [MWIDTH-1:0][MAX_UOPS-1:0][UOP_W-1:0] exp_uop;
	logic                                    prev_req;
	logic                                    prev_ack;

	function automatic logic [UOP_W-1:0] make_uop(uop_op_e op, logic [5:0] d,
			logic [5:0] s1, logic [5:0] s2);
		return {op, d, s1, s2};
	endfunction

	// Expansion rules of one raw instruction, clipped to the slot count
	function automatic void expand(input logic [31:0] ir, input om_e om, output int n,
			output logic [MAX_UOPS-1:0][UOP_W-1:0] list);
		logic [3:0][UOP_W-1:0] seq;
		logic [5:0]            rd;
		logic [5:0]            rs1;
		logic [5:0]            rs2;
		seq = '0;
		rd  = ir[9:4];
		rs1 = ir[15:10];
		rs2 = ir[21:16];
		n   = 1;
		case (ir[3:0])
			4'd0: n = 0;
			4'd1: seq[0] = make_uop(U_ADD, rd, rs1, rs2);
			4'd2: seq[0] = make_uop(U_SUB, rd, rs1, rs2);
			4'd3: seq[0] = make_uop(U_LD, rd, rs1, 6'd0);
			4'd4: seq[0] = make_uop(U_ST, 6'd0, rs1, rs2);
			4'd5: begin
				seq[0] = make_uop(U_DEC, 6'd63, 6'd63, 6'd0);
				seq[1] = make_uop(U_ST, 6'd0, 6'd63, rs1);
				n = 2;
			end
			4'd6: begin
				seq[0] = make_uop(U_LD, rd, 6'd63, 6'd0);
				seq[1] = make_uop(U_INC, 6'd63, 6'd63, 6'd0);
				n = 2;
			end
			4'd7: begin
				n = rs2[1:0] + 1;
				// Register numbers wrap modulo 64
				for (int i = 0; i < n; i++) begin
					seq[i] = make_uop(U_MOV, 6'(rd + i), 6'(rs1 + i), 6'd0);
				end
			end
			4'd8: seq[0] = make_uop((om == OM_SUPER) ? U_SYS : U_TRAP, 6'd0, 6'd0, 6'd0);
			default: seq[0] = make_uop(U_TRAP, 6'd0, 6'd0, 6'd0);
		endcase
		if (n > MAX_UOPS) begin
			n = MAX_UOPS;
		end
		for (int i = 0; i < MAX_UOPS; i++) begin
			list[i] = (i < 4) ? seq[i] : '0;
		end
	endfunction

	// Rising edge updates the model with the inputs it captured
	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mode_m[0]  = OM_USER;
			mode_m[1]  = OM_USER;
			exp_ack    = 1'b0;
			exp_valid  = '0;
			have_group = 1'b0;
		end else begin
			// Translation sees the mode from before this edge
			if (en) begin
				for (int l = 0; l < MWIDTH; l++) begin
					expand(in_instr[l], mode_m[in_thread], exp_cnt[l], exp_uop[l]);
				end
				exp_valid  = stomp ? '0 : in_valid;
				exp_thread = in_thread;
				exp_tag    = in_tag;
				have_group = 1'b1;
			end
			// Req high with ack low means ack rises on this edge
			if (cfg_req && !exp_ack) begin
				mode_m[cfg_thread] = cfg_om;
			end
			exp_ack = cfg_req;
		end
	end

	// =========================================================================
	// Comparison at the falling edge
	// =========================================================================

	initial begin
		error_count = 0;
		check_count = 0;
		prev_req    = 1'b0;
		prev_ack    = 1'b0;
	end

	task automatic check_field(string what, logic [31:0] got, logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// Outputs are compared once reset has been released
	always @(negedge clk) begin
		if (arst_n) begin
			check_field("out_valid", 32'(out_valid), 32'(exp_valid));
			check_field("cfg_ack", 32'(cfg_ack), 32'(exp_ack));
			// Four-phase ordering against the previous sample
			if (cfg_ack && !prev_ack && !prev_req) begin
				error_count++;
				$display("[ERROR] %0t ns: cfg_ack rose before cfg_req", $time);
			end
			if (!cfg_ack && prev_ack && prev_req) begin
				error_count++;
				$display("[ERROR] %0t ns: cfg_ack fell while cfg_req was high", $time);
			end
			prev_req = cfg_req;
			prev_ack = cfg_ack;
			if (have_group) begin
				check_field("out_thread", 32'(out_thread), 32'(exp_thread));
				check_field("out_tag", 32'(out_tag), 32'(exp_tag));
			end
			for (int l = 0; l < MWIDTH; l++) begin
				if (exp_valid[l]) begin
					check_field($sformatf("uop_count[%0d]", l), 32'(uop_count[l]),
						exp_cnt[l]);
					for (int i = 0; i < exp_cnt[l]; i++) begin
						check_field($sformatf("uop[%0d][%0d]", l, i), 32'(uop[l][i]),
							32'(exp_uop[l][i]));
					end
				end
			end
		end
	end

endmodule

// ==== tb/tb_mot.sv ====
// Testbench top for the translation subsystem; drives random fetch groups and host mode writes
`timescale 1ns/100ps

module tb_mot;

	import mot_pkg::*;

	// =========================================================================
	// Test setup
	// =========================================================================

	localparam int MWIDTH         = 2;
	localparam int MAX_UOPS       = 4;
	localparam int TAG_W          = 8;
	localparam int CNT_W          = $clog2(MAX_UOPS + 1);
	localparam int RESET_CYCLES   = 4;
	localparam int N_CYCLES       = 400;
	// A host write is started about this often
	localparam int CFG_GAP        = 50;
	// Generous margin over reset, stimulus, drain and the handshakes
	localparam int TIMEOUT_CYCLES = 5 * N_CYCLES;

	logic                                    clk;
	logic                                    arst_n;
	logic                                    cfg_req;
	logic [THREAD_W-1:0]                     cfg_thread;
	om_e                                     cfg_om;
	logic                                    cfg_ack;
	logic                                    en;
	logic                                    stomp;
	logic [MWIDTH-1:0]                       in_valid;
	logic [THREAD_W-1:0]                     in_thread;
	logic [TAG_W-1:0]                        in_tag;
	logic [MWIDTH-1:0][INSTR_W-1:0]          in_instr;
	logic [MWIDTH-1:0]                       out_valid;
	logic [THREAD_W-1:0]                     out_thread;
	logic [TAG_W-1:0]                        out_tag;
	logic [MWIDTH-1:0][CNT_W-1:0]            uop_count;
	logic [MWIDTH-1:0][MAX_UOPS-1:0][UOP_W-1:0] uop;

	int                  error_count;
	int                  check_count;
	int                  cycle_cnt = 0;
	logic [31:0]         lfsr_state = 32'h830e0801;
	// Hand-off from the stimulus loop to the host process
	logic                cfg_pending;
	logic                cfg_busy;
	logic [THREAD_W-1:0] cfg_next_thread;
	om_e                 cfg_next_om;

	mot_top #(
		.MWIDTH  (MWIDTH),
		.MAX_UOPS(MAX_UOPS),
		.TAG_W   (TAG_W)
	) uut (
		.clk(clk), .arst_n(arst_n),
		.cfg_req(cfg_req), .cfg_thread(cfg_thread), .cfg_om(cfg_om), .cfg_ack(cfg_ack),
		.en(en), .stomp(stomp), .in_valid(in_valid), .in_thread(in_thread),
		.in_tag(in_tag), .in_instr(in_instr),
		.out_valid(out_valid), .out_thread(out_thread), .out_tag(out_tag),
		.uop_count(uop_count), .uop(uop)
	);

	mot_checker #(
		.MWIDTH  (MWIDTH),
		.MAX_UOPS(MAX_UOPS),
		.TAG_W   (TAG_W)
	) u_check (
		.clk(clk), .arst_n(arst_n),
		.cfg_req(cfg_req), .cfg_thread(cfg_thread), .cfg_om(cfg_om), .cfg_ack(cfg_ack),
		.en(en), .stomp(stomp), .in_valid(in_valid), .in_thread(in_thread),
		.in_tag(in_tag), .in_instr(in_instr),
		.out_valid(out_valid), .out_thread(out_thread), .out_tag(out_tag),
		.uop_count(uop_count), .uop(uop),
		.error_count(error_count), .check_count(check_count)
	);

	// =========================================================================
	// Random source
	// =========================================================================

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken, collected LSB last
	function automatic logic [31:0] take_bits(int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// Mostly legal opcodes, and now and then rd near 63 so MOVM wraps
	function automatic logic [31:0] random_instr();
		logic [31:0] word;
		word = take_bits(32);
		if (take_bits(3) != 0) begin
			word[3:0] = 4'(take_bits(4) % 9);
		end
		if (take_bits(2) == 0) begin
			word[9:4] = {4'hf, 2'(take_bits(2))};
		end
		return word;
	endfunction

	// =========================================================================
	// Clock, host and stimulus
	// =========================================================================

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Four-phase write as seen from the host side
	task automatic write_mode(logic [THREAD_W-1:0] thread, om_e mode);
		@(posedge clk);
		cfg_thread <= thread;
		cfg_om     <= mode;
		cfg_req    <= 1'b1;
		do @(negedge clk); while (!cfg_ack);
		@(posedge clk);
		cfg_req <= 1'b0;
		do @(negedge clk); while (cfg_ack);
	endtask

	// Host process picks up write requests at the falling edge
	initial begin
		forever begin
			@(negedge clk);
			if (cfg_pending) begin
				cfg_busy    = 1'b1;
				cfg_pending = 1'b0;
				write_mode(cfg_next_thread, cfg_next_om);
				cfg_busy    = 1'b0;
			end
		end
	end

	// One new group, stall or stomp per clock
	task automatic drive_group();
		en        <= (take_bits(3) != 0);
		stomp     <= (take_bits(4) == 0);
		in_valid  <= MWIDTH'(take_bits(MWIDTH));
		in_thread <= THREAD_W'(take_bits(THREAD_W));
		in_tag    <= TAG_W'(take_bits(TAG_W));
		for (int l = 0; l < MWIDTH; l++) begin
			in_instr[l] <= random_instr();
		end
	endtask

	initial begin
		arst_n      = 1'b0;
		cfg_req     = 1'b0;
		cfg_thread  = '0;
		cfg_om      = OM_USER;
		en          = 1'b0;
		stomp       = 1'b0;
		in_valid    = '0;
		in_thread   = '0;
		in_tag      = '0;
		in_instr    = '0;
		cfg_pending = 1'b0;
		cfg_busy    = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		for (int c = 0; c < N_CYCLES; c++) begin
			@(posedge clk);
			drive_group();
			// First write lands mid-way through the first window
			if (c % CFG_GAP == CFG_GAP / 2) begin
				cfg_next_thread = THREAD_W'(take_bits(THREAD_W));
				cfg_next_om     = om_e'(take_bits(1));
				cfg_pending     = 1'b1;
			end
		end
		@(posedge clk);
		en    <= 1'b0;
		stomp <= 1'b0;
		wait (!cfg_pending && !cfg_busy);
		repeat (4) @(posedge clk);
		@(negedge clk);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Watchdog against a stuck handshake
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("The run timed out after %0d cycles", cycle_cnt);
			$display("Testbench failed");
			$finish;
		end
	end

endmodule

// ==== filelist.f ====
src/mot_pkg.sv
src/mot_cfg_regs.sv
src/microop_mem.sv
src/pipeline_mot.sv
src/mot_top.sv
tb/mot_checker.sv
tb/tb_mot.sv

// ==== Bender.yml ====
package:
  name: mot

sources:
  # Package first, then blocks bottom up
  - files:
      - src/mot_pkg.sv
      - src/mot_cfg_regs.sv
      - src/microop_mem.sv
      - src/pipeline_mot.sv
      - src/mot_top.sv

  - target: simulation
    files:
      - tb/mot_checker.sv
      - tb/tb_mot.sv
